/* verilog/gat_params.svh */
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// feature vector layout coming out of the layer datapath
`define NUM_FEATURE_OUT    4
`define DATA_WIDTH         16
`define NEW_FEATURE_WIDTH  (`NUM_FEATURE_OUT * `DATA_WIDTH)

// feature bram, word addressed
`define FEATURE_ADDR_W     8

// vectors buffered ahead of the serializer
`define FEATURE_FIFO_DEPTH 4

// host side, byte addressed
`define AXIL_ADDR_W        10

`endif

/* verilog/gat_pkg.sv */
`include "gat_params.svh"

package gat_pkg;

  // one word as stored in the feature bram
  typedef logic [`DATA_WIDTH-1:0]                 feat_word_t;

  // whole vector, word 0 in the low bits
  typedef logic [`NEW_FEATURE_WIDTH-1:0]          feat_vec_t;

  typedef logic [`FEATURE_ADDR_W-1:0]             feat_addr_t;

  // word index inside a vector
  typedef logic [$clog2(`NUM_FEATURE_OUT)-1:0]    beat_cnt_t;

  typedef logic [`AXIL_ADDR_W-1:0]                axil_addr_t;
  typedef logic [1:0]                             axil_resp_t;

  typedef enum logic [1:0] {
    rd_idle,  // waiting for an address
    rd_req,   // read request out to the arbiter
    rd_wait,  // bram output settles this cycle
    rd_resp   // holding the r channel
  } rd_state_e;

endpackage

/* verilog/feature_mem_if.sv */
`timescale 1ns/1ns

// one client's path into the shared feature bram
interface feature_mem_if import gat_pkg::*; ();

  logic        req;    // held until gnt
  logic        we;
  feat_addr_t  addr;
  feat_word_t  wdata;
  logic        gnt;    // access done at the edge with req && gnt
  feat_word_t  rdata;  // valid the cycle after a read grant

  modport client (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

/* verilog/feature_fifo.sv */
`timescale 1ns/1ns
`include "gat_params.svh"

module feature_fifo import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  feat_vec_t  din,
  input  logic       wr_vld,
  input  logic       rd_vld,
  output feat_vec_t  dout,
  output logic       empty,
  output logic       full
);

  localparam int DEPTH = `FEATURE_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  feat_vec_t          mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;  // occupancy, 0..DEPTH
  logic               do_wr;
  logic               do_rd;

  assign do_wr = wr_vld && !full;  // push into a full fifo is dropped
  assign do_rd = rd_vld && !empty;

  assign empty = (count == '0);
  assign full  = (count == (PTR_W+1)'(DEPTH));
  assign dout  = mem[rd_ptr];  // head is visible without a read strobe

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* verilog/feature_controller.sv */
`timescale 1ns/1ns
`include "gat_params.svh"

module feature_controller import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  feat_vec_t  new_feature,
  input  logic       new_feature_vld,
  output logic       new_feature_rdy,
  feature_mem_if.client mem
);

  localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(`NUM_FEATURE_OUT - 1);

  feat_vec_t   fifo_dout;
  logic        fifo_wr;
  logic        fifo_rd;
  logic        fifo_empty;
  logic        fifo_full;

  beat_cnt_t   beat;       // word of the head vector going out now
  feat_addr_t  wr_addr;    // running word count, wraps at bram depth
  logic        word_done;

  feature_fifo feature_fifo_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (new_feature),
    .wr_vld (fifo_wr),
    .rd_vld (fifo_rd),
    .dout   (fifo_dout),
    .empty  (fifo_empty),
    .full   (fifo_full)
  );

  // back-pressure straight from the fifo level
  assign new_feature_rdy = !fifo_full;
  assign fifo_wr         = new_feature_vld && new_feature_rdy;

  // one write request per word while a vector sits at the head
  assign mem.req   = !fifo_empty;
  assign mem.we    = 1'b1;
  assign mem.addr  = wr_addr;
  assign mem.wdata = fifo_dout[beat * `DATA_WIDTH +: `DATA_WIDTH];  // lowest word first

  assign word_done = mem.req && mem.gnt;
  assign fifo_rd   = word_done && (beat == LAST_BEAT);  // pop after the last word lands

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat    <= '0;
      wr_addr <= '0;
    end else if (word_done) begin
      // stalled grants leave beat and address where they are
      beat    <= (beat == LAST_BEAT) ? '0 : beat + 1'b1;
      wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

/* verilog/axil_feature_reader.sv */
`timescale 1ns/1ns
`include "gat_params.svh"

module axil_feature_reader import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  axil_addr_t  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output feat_word_t  s_axil_rdata,
  output axil_resp_t  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready,
  feature_mem_if.client mem
);

  localparam axil_resp_t RESP_OKAY = 2'b00;

  rd_state_e   state;
  rd_state_e   state_nxt;
  feat_addr_t  rd_addr;   // word address of the pending read
  feat_word_t  rd_data;   // held for the r channel

  // only one read in flight, so the address channel opens in idle only
  assign s_axil_arready = (state == rd_idle);
  assign s_axil_rvalid  = (state == rd_resp);
  assign s_axil_rdata   = rd_data;
  assign s_axil_rresp   = RESP_OKAY;  // every word address is backed by the bram

  assign mem.req   = (state == rd_req);
  assign mem.we    = 1'b0;
  assign mem.addr  = rd_addr;
  assign mem.wdata = '0;

  always_comb begin
    state_nxt = state;
    case (state)
      rd_idle: begin
        if (s_axil_arvalid) begin
          state_nxt = rd_req;
        end
      end
      rd_req: begin
        if (mem.gnt) begin
          state_nxt = rd_wait;  // bram reads at this edge
        end
      end
      rd_wait: begin
        state_nxt = rd_resp;
      end
      rd_resp: begin
        if (s_axil_rready) begin
          state_nxt = rd_idle;
        end
      end
      default: begin
        state_nxt = rd_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rd_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (s_axil_arvalid && s_axil_arready) begin
      // byte address to word address
      rd_addr <= s_axil_araddr[`AXIL_ADDR_W-1:2];
    end
    if (state == rd_wait) begin
      rd_data <= mem.rdata;
    end
  end

endmodule

/* verilog/feature_mem_arbiter.sv */
`timescale 1ns/1ns

module feature_mem_arbiter import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  feature_mem_if.arbiter wr_port,
  feature_mem_if.arbiter rd_port,
  output logic        bram_en,
  output logic        bram_we,
  output feat_addr_t  bram_addr,
  output feat_word_t  bram_wdata,
  input  feat_word_t  bram_rdata
);

  logic  wr_first;  // writer wins a tie when set
  logic  gnt_wr;
  logic  gnt_rd;

  // a lone request is granted at once, a tie goes to the one that waited
  assign gnt_wr = wr_port.req && (!rd_port.req || wr_first);
  assign gnt_rd = rd_port.req && !gnt_wr;

  assign wr_port.gnt = gnt_wr;
  assign rd_port.gnt = gnt_rd;

  // read data fans out to both clients, only the granted reader samples it
  assign wr_port.rdata = bram_rdata;
  assign rd_port.rdata = bram_rdata;

  assign bram_en = gnt_wr || gnt_rd;

  always_comb begin
    if (gnt_wr) begin
      bram_we    = wr_port.we;
      bram_addr  = wr_port.addr;
      bram_wdata = wr_port.wdata;
    end else if (gnt_rd) begin
      bram_we    = rd_port.we;
      bram_addr  = rd_port.addr;
      bram_wdata = rd_port.wdata;
    end else begin
      bram_we    = 1'b0;
      bram_addr  = rd_port.addr;  // keeps the read port pointed somewhere sane
      bram_wdata = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_first <= 1'b1;
    end else if (gnt_wr) begin
      wr_first <= 1'b0;  // hand priority over
    end else if (gnt_rd) begin
      wr_first <= 1'b1;
    end
  end

endmodule

/* verilog/feature_bram.sv */
`timescale 1ns/1ns
`include "gat_params.svh"

module feature_bram import gat_pkg::*; (
  input  logic        clk,
  input  logic        en,
  input  logic        we,
  input  feat_addr_t  addr,
  input  feat_word_t  wdata,
  output feat_word_t  rdata
);

  localparam int DEPTH = 1 << `FEATURE_ADDR_W;

  feat_word_t  mem [DEPTH];  // contents undefined until written

  always_ff @(posedge clk) begin
    if (en && we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read returns old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* verilog/gat_feature_store.sv */
`timescale 1ns/1ns

module gat_feature_store import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  feat_vec_t   new_feature,
  input  logic        new_feature_vld,
  output logic        new_feature_rdy,
  input  axil_addr_t  s_axil_araddr,
  input  logic        s_axil_arvalid,
  output logic        s_axil_arready,
  output feat_word_t  s_axil_rdata,
  output axil_resp_t  s_axil_rresp,
  output logic        s_axil_rvalid,
  input  logic        s_axil_rready
);

  logic        bram_en;
  logic        bram_we;
  feat_addr_t  bram_addr;
  feat_word_t  bram_wdata;
  feat_word_t  bram_rdata;

  feature_mem_if wr_port ();  // controller side
  feature_mem_if rd_port ();  // host reader side

  feature_controller feature_controller_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .new_feature     (new_feature),
    .new_feature_vld (new_feature_vld),
    .new_feature_rdy (new_feature_rdy),
    .mem             (wr_port.client)
  );

  axil_feature_reader axil_feature_reader_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .mem            (rd_port.client)
  );

  feature_mem_arbiter feature_mem_arbiter_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_port    (wr_port.arbiter),
    .rd_port    (rd_port.arbiter),
    .bram_en    (bram_en),
    .bram_we    (bram_we),
    .bram_addr  (bram_addr),
    .bram_wdata (bram_wdata),
    .bram_rdata (bram_rdata)
  );

  feature_bram feature_bram_inst (
    .clk   (clk),
    .en    (bram_en),
    .we    (bram_we),
    .addr  (bram_addr),
    .wdata (bram_wdata),
    .rdata (bram_rdata)
  );

endmodule

/* verification/gat_feature_store_checker.sv */
`timescale 1ns/1ns

module gat_feature_store_checker import gat_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        arready,
  input logic        rvalid,
  input logic        rready,
  input feat_word_t  rdata,
  input logic        req_wr,
  input logic        gnt_wr,
  input logic        req_rd,
  input logic        gnt_rd
);

  // word must hold while the host stalls the r channel
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("r channel changed while rready was low");

  one_read: assert property (@(posedge clk) disable iff (!rst_n) !(arready && rvalid))
    else $error("arready and rvalid high together");

  one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt_wr && gnt_rd))
    else $error("both arbiter grants high");

  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!gnt_wr || req_wr) && (!gnt_rd || req_rd))
    else $error("grant given without a request");

endmodule

bind gat_feature_store gat_feature_store_checker gat_feature_store_checker_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .arready (s_axil_arready),
  .rvalid  (s_axil_rvalid),
  .rready  (s_axil_rready),
  .rdata   (s_axil_rdata),
  .req_wr  (wr_port.req),
  .gnt_wr  (wr_port.gnt),
  .req_rd  (rd_port.req),
  .gnt_rd  (rd_port.gnt)
);

/* verification/gat_feature_store_tb.sv */
`timescale 1ns/1ns
`include "gat_params.svh"

module gat_feature_store_tb import gat_pkg::*; ();

  localparam int CYCLE_LIMIT = 20000;  // ample margin over all tests together
  localparam int WRAP_VECTORS = 69;    // 276 words reach past the bram depth
  localparam axil_resp_t RESP_OKAY = 2'b00;

  logic        clk = 1'b0;
  logic        rst_n;
  feat_vec_t   new_feature;
  logic        new_feature_vld;
  logic        new_feature_rdy;
  axil_addr_t  s_axil_araddr;
  logic        s_axil_arvalid;
  logic        s_axil_arready;
  feat_word_t  s_axil_rdata;
  axil_resp_t  s_axil_rresp;
  logic        s_axil_rvalid;
  logic        s_axil_rready;

  feat_word_t  exp_mem [256];
  logic        exp_vld [256];
  feat_addr_t  model_addr;  // next word the dut is expected to write
  int          vec_total;
  int          errors;
  int          passes;
  int          cycles = 0;
  logic [31:0] rng_state = 32'd68;

  gat_feature_store gat_feature_store_inst (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the dut stopped responding", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic feat_vec_t rand_vec();
    return {next_rand(), next_rand()};
  endfunction

  task automatic check_word(input string name, input feat_word_t exp, input feat_word_t act);
    if (act !== exp) begin
      $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end else passes++;
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
      $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end else passes++;
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
      errors++;
    end else passes++;
  endtask

  // vector lands word by word, lowest slice first, at the running address
  task automatic record_vector(input feat_vec_t vec);
    for (int k = 0; k < `NUM_FEATURE_OUT; k++) begin
      exp_mem[model_addr] = vec[k*`DATA_WIDTH +: `DATA_WIDTH];
      exp_vld[model_addr] = 1'b1;
      model_addr++;
    end
    vec_total++;
  endtask

  task automatic send_vectors(input int count, input int vld_pct);
    int sent;
    feat_vec_t vec;
    sent = 0;
    vec = rand_vec();
    while (sent < count) begin
      @(posedge clk);
      if (new_feature_vld && new_feature_rdy) begin
        record_vector(new_feature);
        sent++;
        vec = rand_vec();
      end
      new_feature     <= vec;
      new_feature_vld <= (sent < count) && ((next_rand() % 100) < vld_pct);
    end
  endtask

  // push every cycle until the fifo reports full
  task automatic fill_fifo(output int accepted);
    accepted = 0;
    new_feature     <= rand_vec();
    new_feature_vld <= 1'b1;
    do begin
      @(posedge clk);
      if (new_feature_vld && new_feature_rdy) begin
        record_vector(new_feature);
        accepted++;
        new_feature <= rand_vec();
      end
    end while (new_feature_rdy);
    new_feature_vld <= 1'b0;
  endtask

  task automatic read_and_compare(input feat_addr_t addr, input int hold);
    int waited;
    waited = 0;
    s_axil_araddr  <= {addr, 2'b00};
    s_axil_arvalid <= 1'b1;
    do @(posedge clk); while (!s_axil_arready);
    s_axil_arvalid <= 1'b0;
    do begin
      s_axil_rready <= (waited >= hold);  // host stalls for hold cycles
      @(posedge clk);
      waited++;
    end while (!(s_axil_rvalid && s_axil_rready));
    s_axil_rready <= 1'b0;
    check_word($sformatf("s_axil_rdata word 0x%h", addr), exp_mem[addr], s_axil_rdata);
    check_resp("s_axil_rresp", RESP_OKAY, s_axil_rresp);
  endtask

  task automatic wait_drain();
    do @(posedge clk); while (!gat_feature_store_inst.feature_controller_inst.fifo_empty);
  endtask

  task automatic finish_test(input string name, input int err_start);
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  initial begin
    int base;
    int accepted;
    int err_start;
    feat_addr_t rd_addrs [30];  // read targets drawn before each fork
    int         rd_holds [30];
    rst_n = 1'b0;
    new_feature = '0;
    new_feature_vld = 1'b0;
    s_axil_araddr = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready = 1'b0;
    model_addr = '0;
    vec_total = 0;
    errors = 0;
    passes = 0;
    for (int i = 0; i < 256; i++) exp_vld[i] = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    err_start = errors;
    check_flag("new_feature_rdy", 1'b1, new_feature_rdy);
    check_flag("s_axil_arready", 1'b1, s_axil_arready);
    check_flag("s_axil_rvalid", 1'b0, s_axil_rvalid);
    finish_test("reset_values", err_start);

    err_start = errors;
    send_vectors(1, 100);
    wait_drain();
    for (int a = 0; a < 4; a++) read_and_compare(feat_addr_t'(a), 0);
    finish_test("single_vector", err_start);

    err_start = errors;
    for (int r = 0; r < 15; r++) begin
      rd_addrs[r] = feat_addr_t'(next_rand() % 4);
      rd_holds[r] = int'(next_rand() % 8);
    end
    fork
      send_vectors(40, 60);
      for (int r = 0; r < 15; r++) read_and_compare(rd_addrs[r], rd_holds[r]);
    join
    wait_drain();
    for (int a = 0; a < 256; a++) begin
      if (exp_vld[a]) read_and_compare(feat_addr_t'(a), int'(next_rand() % 4));
    end
    finish_test("random_burst", err_start);

    err_start = errors;
    base = int'(model_addr);
    for (int r = 0; r < 30; r++) rd_addrs[r] = feat_addr_t'(next_rand() % base);
    fork
      send_vectors(12, 70);
      for (int r = 0; r < 30; r++) read_and_compare(rd_addrs[r], 0);
    join
    wait_drain();
    for (int a = base; a < base + 48; a++) read_and_compare(feat_addr_t'(a), 0);
    finish_test("concurrent_reads", err_start);

    err_start = errors;
    base = int'(model_addr);
    fork
      read_and_compare(feat_addr_t'(0), 40);  // parks the reader in rd_resp
      fill_fifo(accepted);
    join
    if (accepted < `FEATURE_FIFO_DEPTH) begin
      $display("fifo reported full after only %0d vectors", accepted);
      errors++;
    end
    wait_drain();
    for (int a = base; a < base + 4 * accepted; a++) read_and_compare(feat_addr_t'(a), 0);
    finish_test("fifo_full", err_start);

    err_start = errors;
    send_vectors(WRAP_VECTORS - vec_total, 80);
    wait_drain();
    for (int a = 0; a < int'(model_addr); a++) read_and_compare(feat_addr_t'(a), 0);
    finish_test("address_wrap", err_start);

    $display("checks passed %0d, errors %0d", passes, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+verilog
verilog/gat_pkg.sv
verilog/feature_mem_if.sv
verilog/feature_fifo.sv
verilog/feature_controller.sv
verilog/axil_feature_reader.sv
verilog/feature_mem_arbiter.sv
verilog/feature_bram.sv
verilog/gat_feature_store.sv
verification/gat_feature_store_checker.sv
verification/gat_feature_store_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gat_feature_store_tb \
  -f project.f -o gat_feature_store_sim > sim.log 2>&1 &&
  ./obj_dir/gat_feature_store_sim >> sim.log 2>&1 ||
  echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
